/* common/queue_table_pkg.sv */
package queue_table_pkg;

    // number of queues is set by the page index width
    localparam int app_idx_width     = 2;
    localparam int queue_table_depth = 2 ** app_idx_width;

    // tail, head and the two halves of the ring address
    localparam int nb_table_fields   = 4;

    typedef logic [app_idx_width-1:0] queue_idx_t;

    // ring pointer as seen by the DMA engine and the host
    typedef logic [31:0] rb_ptr_t;

    // one entry of one table column
    typedef logic [31:0] table_word_t;

    // kernel-memory address of a ring, built from l_addr and h_addr
    typedef logic [63:0] kmem_addr_t;

    // column order matches the word slots of a BAR line
    typedef enum logic [1:0] {
        field_tail,
        field_head,
        field_l_addr,
        field_h_addr
    } table_field_t;

endpackage

/* common/pcie_bar_pkg.sv */
package pcie_bar_pkg;

    localparam int pcie_addr_width = 16;

    // bytes per register word
    localparam int reg_size = 4;

    // queue index starts at this address bit, one 4 KiB page per queue
    localparam int page_lsb = 12;

    // first 64-byte line of the ring buffer region
    localparam int rb_bram_offset = 256;

    // word slots of a 512-bit register line
    localparam int slot_tail        = 0;
    localparam int slot_head        = 1;
    localparam int slot_l_addr      = 2;
    localparam int slot_h_addr      = 3;
    localparam int slot_c2f_tail    = 4;
    localparam int slot_c2f_head    = 5;
    localparam int slot_c2f_kmem_lo = 6;
    localparam int slot_c2f_kmem_hi = 7;

    typedef logic [pcie_addr_width-1:0] bar_addr_t;

    // one BAR data line and its byte enables
    typedef logic [511:0] bar_line_t;
    typedef logic [63:0]  bar_be_t;

endpackage

/* common/queue_table_if.sv */
`timescale 1ns/1ps

interface queue_table_if;
    import queue_table_pkg::*;

    // one address for all columns of the table
    queue_idx_t addr;

    // per-column strobes
    logic [nb_table_fields-1:0] wr_en;
    logic [nb_table_fields-1:0] rd_en;

    // per-column data, indexed by table_field_t
    table_word_t wr_data [nb_table_fields];
    table_word_t rd_data [nb_table_fields];

    modport requester (
        output addr,
        output wr_en,
        output rd_en,
        output wr_data,
        input  rd_data
    );

    modport ram (
        input  addr,
        input  wr_en,
        input  rd_en,
        input  wr_data,
        output rd_data
    );

endinterface

/* queue_table/queue_state_ram.sv */
`timescale 1ns/1ps

module queue_state_ram #(
    parameter queue_table_pkg::table_field_t field = queue_table_pkg::field_tail
) (
    input  logic       pcie_clk,
    queue_table_if.ram a,
    queue_table_if.ram b
);
    import queue_table_pkg::*;

    table_word_t mem [queue_table_depth];
    table_word_t a_stage;
    table_word_t b_stage;

    // writes land on the sampling edge
    always_ff @(posedge pcie_clk) begin
        if (a.wr_en[field]) begin
            mem[a.addr] <= a.wr_data[field];
        end
        if (b.wr_en[field]) begin
            mem[b.addr] <= b.wr_data[field];
        end
    end

    // first read stage, write-first on each port
    always_ff @(posedge pcie_clk) begin
        if (a.rd_en[field]) begin
            a_stage <= a.wr_en[field] ? a.wr_data[field] : mem[a.addr];
        end
        if (b.rd_en[field]) begin
            b_stage <= b.wr_en[field] ? b.wr_data[field] : mem[b.addr];
        end
    end

    // output register holds its word until the next read
    always_ff @(posedge pcie_clk) begin
        a.rd_data[field] <= a_stage;
        b.rd_data[field] <= b_stage;
    end

endmodule

/* queue_table/queue_port_ctrl.sv */
`timescale 1ns/1ps

module queue_port_ctrl (
    input  logic                     pcie_clk,
    input  logic                     pcie_reset_n,
    input  pcie_bar_pkg::bar_addr_t  pcie_address,
    input  logic                     pcie_read,
    input  logic                     pcie_write,
    input  pcie_bar_pkg::bar_line_t  pcie_writedata,
    input  pcie_bar_pkg::bar_be_t    pcie_byteenable,
    queue_table_if.requester         port,
    output queue_table_pkg::rb_ptr_t c2f_wr_data,
    output logic                     c2f_tail_wr,
    output logic                     c2f_kmem_lo_wr,
    output logic                     c2f_kmem_hi_wr,
    output logic                     reply_valid
);
    import queue_table_pkg::*;
    import pcie_bar_pkg::*;

    typedef enum logic [1:0] {
        idle,
        read_pending,
        read_in_flight
    } port_state_t;

    port_state_t state;
    queue_idx_t  page_idx;
    queue_idx_t  rd_addr;
    logic        reg_region;
    logic        reg_read;
    logic [1:0]  rd_pipe;
    logic [2:0]  c2f_new;
    logic [2:0]  c2f_pend;
    logic [2:0]  c2f_sel;
    rb_ptr_t     c2f_data [3];

    // a slot counts only with all four byte lanes enabled
    function automatic logic slot_en(bar_be_t be, int slot);
        return &be[slot*reg_size +: reg_size];
    endfunction

    function automatic table_word_t slot_word(bar_line_t line, int slot);
        return line[slot*reg_size*8 +: reg_size*8];
    endfunction

    assign page_idx = pcie_address[page_lsb +: app_idx_width];

    // 64-byte line number, lines below the ring buffer hold the registers
    assign reg_region = pcie_address[pcie_addr_width-1:6] < rb_bram_offset;
    assign reg_read   = pcie_read && reg_region;

    // bit 0 tail, bit 1 kmem low, bit 2 kmem high
    assign c2f_new = {3{pcie_write}} & {slot_en(pcie_byteenable, slot_c2f_kmem_hi),
                                        slot_en(pcie_byteenable, slot_c2f_kmem_lo),
                                        slot_en(pcie_byteenable, slot_c2f_tail)};

    // one c2f register per cycle over the shared data bus, lowest first
    assign c2f_sel        = c2f_pend & (~c2f_pend + 3'd1);
    assign c2f_tail_wr    = c2f_sel[0];
    assign c2f_kmem_lo_wr = c2f_sel[1];
    assign c2f_kmem_hi_wr = c2f_sel[2];

    always_comb begin
        if (c2f_sel[2]) begin
            c2f_wr_data = c2f_data[2];
        end else if (c2f_sel[1]) begin
            c2f_wr_data = c2f_data[1];
        end else begin
            c2f_wr_data = c2f_data[0];
        end
    end

    // reply lines up with the port-B read data
    assign reply_valid = rd_pipe[1];

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state      <= idle;
            port.wr_en <= '0;
            port.rd_en <= '0;
            rd_pipe    <= '0;
            c2f_pend   <= '0;
        end else begin
            port.wr_en <= '0;
            port.rd_en <= '0;
            rd_pipe    <= {rd_pipe[0], port.rd_en[field_tail]};
            c2f_pend   <= (c2f_pend & ~c2f_sel) | c2f_new;

            // writes first, the pending read waits for a free edge
            if (pcie_write) begin
                port.wr_en[field_head]   <= slot_en(pcie_byteenable, slot_head);
                port.wr_en[field_l_addr] <= slot_en(pcie_byteenable, slot_l_addr);
                port.wr_en[field_h_addr] <= slot_en(pcie_byteenable, slot_h_addr);
            end else if (state == read_pending) begin
                port.rd_en <= '1;
                state      <= read_in_flight;
            end

            if (reg_read) begin
                state <= read_pending;
            end else if (state == read_in_flight && reply_valid) begin
                state <= idle;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_write) begin
            port.addr <= page_idx;
            // tail slot is owned by the DMA engine
            port.wr_data[field_tail]   <= slot_word(pcie_writedata, slot_tail);
            port.wr_data[field_head]   <= slot_word(pcie_writedata, slot_head);
            port.wr_data[field_l_addr] <= slot_word(pcie_writedata, slot_l_addr);
            port.wr_data[field_h_addr] <= slot_word(pcie_writedata, slot_h_addr);
        end else if (state == read_pending) begin
            port.addr <= rd_addr;
        end
        if (reg_read) begin
            rd_addr <= page_idx;
        end
        if (c2f_new[0]) begin
            c2f_data[0] <= slot_word(pcie_writedata, slot_c2f_tail);
        end
        if (c2f_new[1]) begin
            c2f_data[1] <= slot_word(pcie_writedata, slot_c2f_kmem_lo);
        end
        if (c2f_new[2]) begin
            c2f_data[2] <= slot_word(pcie_writedata, slot_c2f_kmem_hi);
        end
    end

    // host keeps a single register read outstanding
    a_single_read: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        reg_read |-> state == idle);

endmodule

/* queue_table/dma_queue_port.sv */
`timescale 1ns/1ps

module dma_queue_port (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,
    input  logic                        queue_rd_en,
    input  logic                        tail_wr_en,
    input  queue_table_pkg::queue_idx_t dma_queue,
    input  queue_table_pkg::rb_ptr_t    new_tail,
    queue_table_if.requester            port,
    output logic                        queue_ready,
    output queue_table_pkg::rb_ptr_t    f2c_tail,
    output queue_table_pkg::rb_ptr_t    f2c_head,
    output queue_table_pkg::kmem_addr_t f2c_kmem_addr
);
    import queue_table_pkg::*;

    table_word_t tail_wr_data;
    logic        rd_in_ram;
    rb_ptr_t     tail_hold;
    rb_ptr_t     head_hold;
    kmem_addr_t  kmem_hold;

    // issue register, then the RAM pipeline
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            port.rd_en  <= '0;
            port.wr_en  <= '0;
            rd_in_ram   <= 1'b0;
            queue_ready <= 1'b0;
        end else begin
            port.rd_en <= {nb_table_fields{queue_rd_en}};
            port.wr_en <= '0;
            // a queue read beats the tail write-back
            if (tail_wr_en && !queue_rd_en) begin
                port.wr_en[field_tail] <= 1'b1;
            end
            rd_in_ram   <= port.rd_en[field_tail];
            queue_ready <= rd_in_ram;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (queue_rd_en || tail_wr_en) begin
            port.addr <= dma_queue;
        end
        if (tail_wr_en) begin
            tail_wr_data <= new_tail;
        end
    end

    // only the tail column is ever written from this side
    always_comb begin
        for (int f = 0; f < nb_table_fields; f++) begin
            port.wr_data[f] = tail_wr_data;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (queue_ready) begin
            tail_hold <= port.rd_data[field_tail];
            head_hold <= port.rd_data[field_head];
            kmem_hold <= {port.rd_data[field_h_addr], port.rd_data[field_l_addr]};
        end
    end

    // RAM words during the ready cycle and the captured copy afterwards
    assign f2c_tail      = queue_ready ? port.rd_data[field_tail] : tail_hold;
    assign f2c_head      = queue_ready ? port.rd_data[field_head] : head_hold;
    assign f2c_kmem_addr = queue_ready ?
        {port.rd_data[field_h_addr], port.rd_data[field_l_addr]} : kmem_hold;

    a_no_rd_wr_overlap: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        !(queue_rd_en && tail_wr_en));

endmodule

/* src/bar_reply.sv */
`timescale 1ns/1ps

module bar_reply (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,
    input  queue_table_pkg::rb_ptr_t    c2f_wr_data,
    input  logic                        c2f_tail_wr,
    input  logic                        c2f_kmem_lo_wr,
    input  logic                        c2f_kmem_hi_wr,
    input  queue_table_pkg::table_word_t table_rd_data [queue_table_pkg::nb_table_fields],
    input  logic                        reply_valid,
    output pcie_bar_pkg::bar_line_t     pcie_readdata,
    output logic                        pcie_readdatavalid
);
    import queue_table_pkg::*;
    import pcie_bar_pkg::*;

    rb_ptr_t    c2f_tail;
    kmem_addr_t c2f_kmem_addr;
    bar_line_t  reply_line;

    // CPU-to-FPGA ring registers
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            c2f_tail           <= '0;
            c2f_kmem_addr      <= '0;
            pcie_readdatavalid <= 1'b0;
        end else begin
            if (c2f_tail_wr) begin
                c2f_tail <= c2f_wr_data;
            end
            if (c2f_kmem_lo_wr) begin
                c2f_kmem_addr[31:0] <= c2f_wr_data;
            end
            if (c2f_kmem_hi_wr) begin
                c2f_kmem_addr[63:32] <= c2f_wr_data;
            end
            pcie_readdatavalid <= reply_valid;
        end
    end

    // slots 8 to 15 stay zero
    always_comb begin
        reply_line = '0;
        reply_line[slot_tail*reg_size*8 +: reg_size*8]        = table_rd_data[field_tail];
        reply_line[slot_head*reg_size*8 +: reg_size*8]        = table_rd_data[field_head];
        reply_line[slot_l_addr*reg_size*8 +: reg_size*8]      = table_rd_data[field_l_addr];
        reply_line[slot_h_addr*reg_size*8 +: reg_size*8]      = table_rd_data[field_h_addr];
        reply_line[slot_c2f_tail*reg_size*8 +: reg_size*8]    = c2f_tail;
        // c2f head is never written by the host
        reply_line[slot_c2f_head*reg_size*8 +: reg_size*8]    = '0;
        reply_line[slot_c2f_kmem_lo*reg_size*8 +: reg_size*8] = c2f_kmem_addr[31:0];
        reply_line[slot_c2f_kmem_hi*reg_size*8 +: reg_size*8] = c2f_kmem_addr[63:32];
    end

    always_ff @(posedge pcie_clk) begin
        if (reply_valid) begin
            pcie_readdata <= reply_line;
        end
    end

endmodule

/* src/pcie_queue_regs_top.sv */
`timescale 1ns/1ps

module pcie_queue_regs_top (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,
    // BAR register window
    input  pcie_bar_pkg::bar_addr_t     pcie_address,
    input  logic                        pcie_read,
    input  logic                        pcie_write,
    input  pcie_bar_pkg::bar_line_t     pcie_writedata,
    input  pcie_bar_pkg::bar_be_t       pcie_byteenable,
    output pcie_bar_pkg::bar_line_t     pcie_readdata,
    output logic                        pcie_readdatavalid,
    // DMA engine side
    input  logic                        queue_rd_en,
    input  logic                        tail_wr_en,
    input  queue_table_pkg::queue_idx_t dma_queue,
    input  queue_table_pkg::rb_ptr_t    new_tail,
    output logic                        queue_ready,
    output queue_table_pkg::rb_ptr_t    f2c_tail,
    output queue_table_pkg::rb_ptr_t    f2c_head,
    output queue_table_pkg::kmem_addr_t f2c_kmem_addr
);
    import queue_table_pkg::*;

    rb_ptr_t c2f_wr_data;
    logic    c2f_tail_wr;
    logic    c2f_kmem_lo_wr;
    logic    c2f_kmem_hi_wr;
    logic    reply_valid;

    // port A serves the DMA engine, port B the BAR window
    queue_table_if port_a ();
    queue_table_if port_b ();

    dma_queue_port u_dma_port (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .queue_rd_en   (queue_rd_en),
        .tail_wr_en    (tail_wr_en),
        .dma_queue     (dma_queue),
        .new_tail      (new_tail),
        .port          (port_a),
        .queue_ready   (queue_ready),
        .f2c_tail      (f2c_tail),
        .f2c_head      (f2c_head),
        .f2c_kmem_addr (f2c_kmem_addr)
    );

    queue_port_ctrl u_bar_port (
        .pcie_clk        (pcie_clk),
        .pcie_reset_n    (pcie_reset_n),
        .pcie_address    (pcie_address),
        .pcie_read       (pcie_read),
        .pcie_write      (pcie_write),
        .pcie_writedata  (pcie_writedata),
        .pcie_byteenable (pcie_byteenable),
        .port            (port_b),
        .c2f_wr_data     (c2f_wr_data),
        .c2f_tail_wr     (c2f_tail_wr),
        .c2f_kmem_lo_wr  (c2f_kmem_lo_wr),
        .c2f_kmem_hi_wr  (c2f_kmem_hi_wr),
        .reply_valid     (reply_valid)
    );

    bar_reply u_reply (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .c2f_wr_data        (c2f_wr_data),
        .c2f_tail_wr        (c2f_tail_wr),
        .c2f_kmem_lo_wr     (c2f_kmem_lo_wr),
        .c2f_kmem_hi_wr     (c2f_kmem_hi_wr),
        .table_rd_data      (port_b.rd_data),
        .reply_valid        (reply_valid),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid)
    );

    // one RAM column per table field
    for (genvar f = 0; f < nb_table_fields; f++) begin : g_column
        queue_state_ram #(
            .field (table_field_t'(f))
        ) u_column (
            .pcie_clk (pcie_clk),
            .a        (port_a),
            .b        (port_b)
        );
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 2
) (
    output logic pcie_clk,
    output logic pcie_reset_n
);

    initial begin
        pcie_clk = 1'b0;
        forever #(period_ns / 2.0) pcie_clk = ~pcie_clk;
    end

    // reset low over the first rising edges
    initial begin
        pcie_reset_n = 1'b0;
        repeat (reset_cycles) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
    end

endmodule

/* verification/tb_pcie_queue_regs.sv */
`timescale 1ns/1ps

module tb_pcie_queue_regs;
    import queue_table_pkg::*;
    import pcie_bar_pkg::*;

    localparam int words_per_test  = 5;
    localparam int max_tests       = 64;
    localparam int cycles_per_test = 200;
    localparam int reply_timeout   = 32;
    localparam int no_reply_window = 20;

    // operation codes of the test file
    localparam logic [31:0] op_end         = 32'h0;
    localparam logic [31:0] op_bar_write   = 32'h1;
    localparam logic [31:0] op_bar_read    = 32'h2;
    localparam logic [31:0] op_dma_tail_wr = 32'h3;
    localparam logic [31:0] op_dma_read    = 32'h4;
    localparam logic [31:0] op_write_burst = 32'h5;
    localparam logic [31:0] op_outside     = 32'h6;

    logic       pcie_clk;
    logic       pcie_reset_n;
    bar_addr_t  pcie_address;
    logic       pcie_read;
    logic       pcie_write;
    bar_line_t  pcie_writedata;
    bar_be_t    pcie_byteenable;
    bar_line_t  pcie_readdata;
    logic       pcie_readdatavalid;
    logic       queue_rd_en;
    logic       tail_wr_en;
    queue_idx_t dma_queue;
    rb_ptr_t    new_tail;
    logic       queue_ready;
    rb_ptr_t    f2c_tail;
    rb_ptr_t    f2c_head;
    kmem_addr_t f2c_kmem_addr;

    logic [31:0] test_words [words_per_test*max_tests];
    // reference model, [queue][field] with fields in slot order
    logic [31:0] ref_table [4][4];
    logic [31:0] ref_c2f_tail;
    logic [63:0] ref_c2f_kmem;
    integer      seed;
    int          n_tests;
    int          error_count  = 0;
    int          tests_failed = 0;
    logic        tests_loaded = 1'b0;

    tb_clock_gen #(.period_ns(4.0), .reset_cycles(2)) u_clock (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n)
    );

    pcie_queue_regs_top u_dut (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pcie_address       (pcie_address),
        .pcie_read          (pcie_read),
        .pcie_write         (pcie_write),
        .pcie_writedata     (pcie_writedata),
        .pcie_byteenable    (pcie_byteenable),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid),
        .queue_rd_en        (queue_rd_en),
        .tail_wr_en         (tail_wr_en),
        .dma_queue          (dma_queue),
        .new_tail           (new_tail),
        .queue_ready        (queue_ready),
        .f2c_tail           (f2c_tail),
        .f2c_head           (f2c_head),
        .f2c_kmem_addr      (f2c_kmem_addr)
    );

    task automatic check_word(string name, logic [63:0] expected, logic [63:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_failure(string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    // one 4 KiB page per queue, bit 14 moves past line 256
    function automatic bar_addr_t page_address(int q, logic outside);
        bar_addr_t addr;
        addr = '0;
        addr[13:12] = q[1:0];
        addr[14] = outside;
        return addr;
    endfunction

    function automatic void apply_slot_write(int q, int s, logic [31:0] word);
        case (s)
            slot_head, slot_l_addr, slot_h_addr: ref_table[q][s] = word;
            slot_c2f_tail:    ref_c2f_tail = word;
            slot_c2f_kmem_lo: ref_c2f_kmem[31:0] = word;
            slot_c2f_kmem_hi: ref_c2f_kmem[63:32] = word;
            default: ;
        endcase
    endfunction

    function automatic bar_line_t expected_line(int q);
        bar_line_t line;
        line = '0;
        for (int f = 0; f < 4; f++) begin
            line[f*32 +: 32] = ref_table[q][f];
        end
        line[slot_c2f_tail*32 +: 32]    = ref_c2f_tail;
        line[slot_c2f_kmem_lo*32 +: 32] = ref_c2f_kmem[31:0];
        line[slot_c2f_kmem_hi*32 +: 32] = ref_c2f_kmem[63:32];
        return line;
    endfunction

    // mask bits 7:0 full slots, bits 15:8 slots with one byte lane missing
    task automatic drive_write_cycle(int q, logic [31:0] mask, logic [31:0] value);
        bar_line_t data;
        bar_be_t   be;
        be = '0;
        for (int s = 0; s < 16; s++) begin
            data[s*32 +: 32] = $random(seed);
        end
        for (int s = 0; s < 8; s++) begin
            if (mask[s]) begin
                data[s*32 +: 32] = value + s;
                be[s*4 +: 4] = 4'hf;
                apply_slot_write(q, s, value + s);
            end else if (mask[s+8]) begin
                be[s*4 +: 4] = 4'h7;
            end
        end
        @(posedge pcie_clk);
        pcie_address    <= page_address(q, 1'b0);
        pcie_write      <= 1'b1;
        pcie_read       <= 1'b0;
        pcie_writedata  <= data;
        pcie_byteenable <= be;
    endtask

    task automatic drive_read_cycle(bar_addr_t addr);
        @(posedge pcie_clk);
        pcie_address <= addr;
        pcie_read    <= 1'b1;
        pcie_write   <= 1'b0;
    endtask

    task automatic drive_bus_idle();
        @(posedge pcie_clk);
        pcie_read  <= 1'b0;
        pcie_write <= 1'b0;
    endtask

    task automatic wait_read_reply(int q, int slot, logic [31:0] expected);
        bar_line_t want;
        int        cycles;
        int        extra;
        cycles = 0;
        extra  = 0;
        do begin
            @(negedge pcie_clk);
            cycles++;
        end while (pcie_readdatavalid !== 1'b1 && cycles < reply_timeout);
        if (pcie_readdatavalid !== 1'b1) begin
            report_failure($sformatf("no pcie_readdatavalid for the read of queue %0d", q));
        end else begin
            want = expected_line(q);
            for (int s = 0; s < 16; s++) begin
                check_word($sformatf("pcie_readdata slot %0d", s),
                           want[s*32 +: 32], pcie_readdata[s*32 +: 32]);
            end
            check_word($sformatf("pcie_readdata slot %0d from file", slot),
                       expected, pcie_readdata[slot*32 +: 32]);
            repeat (8) begin
                @(negedge pcie_clk);
                if (pcie_readdatavalid === 1'b1) begin
                    extra++;
                end
            end
            if (extra != 0) begin
                report_failure("more than one pcie_readdatavalid for a single read");
            end
        end
    endtask

    task automatic dma_tail_write(int q, logic [31:0] tail);
        @(posedge pcie_clk);
        tail_wr_en <= 1'b1;
        dma_queue  <= q[1:0];
        new_tail   <= tail;
        ref_table[q][0] = tail;
        @(posedge pcie_clk);
        tail_wr_en <= 1'b0;
        repeat (2) @(posedge pcie_clk);
    endtask

    task automatic dma_read(int q, logic [31:0] expected_tail);
        int latency;
        @(posedge pcie_clk);
        queue_rd_en <= 1'b1;
        dma_queue   <= q[1:0];
        @(posedge pcie_clk);
        queue_rd_en <= 1'b0;
        // counts the sampling edges after the edge that took the request
        latency = 0;
        do begin
            @(negedge pcie_clk);
            latency++;
        end while (queue_ready !== 1'b1 && latency < reply_timeout);
        if (queue_ready !== 1'b1) begin
            report_failure($sformatf("no queue_ready for the DMA read of queue %0d", q));
        end else begin
            check_word("queue_ready latency", 64'(3), 64'(latency));
            check_word("f2c_tail", ref_table[q][0], f2c_tail);
            check_word("f2c_tail from file", expected_tail, f2c_tail);
            check_word("f2c_head", ref_table[q][1], f2c_head);
            check_word("f2c_kmem_addr", {ref_table[q][3], ref_table[q][2]}, f2c_kmem_addr);
        end
        repeat (2) @(posedge pcie_clk);
    endtask

    task automatic run_test(int t);
        logic [31:0] op;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] expected;
        int          q;
        int          errors_before;
        logic        seen;
        op       = test_words[t*words_per_test];
        q        = int'(test_words[t*words_per_test+1]);
        mask     = test_words[t*words_per_test+2];
        value    = test_words[t*words_per_test+3];
        expected = test_words[t*words_per_test+4];
        errors_before = error_count;
        seen = 1'b0;
        case (op)
            op_bar_write: begin
                drive_write_cycle(q, mask, value);
                drive_bus_idle();
                repeat (4) @(posedge pcie_clk);
            end
            op_bar_read: begin
                drive_read_cycle(page_address(q, 1'b0));
                drive_bus_idle();
                wait_read_reply(q, int'(mask[3:0]), expected);
            end
            op_dma_tail_wr: dma_tail_write(q, value);
            op_dma_read: dma_read(q, expected);
            op_write_burst: begin
                // the read lands between writes and waits for them
                drive_write_cycle(q, mask, value);
                drive_read_cycle(page_address(q, 1'b0));
                drive_write_cycle(q, mask, value + 32'h100);
                drive_write_cycle(q, mask, value + 32'h200);
                drive_bus_idle();
                wait_read_reply(q, slot_head, expected);
            end
            op_outside: begin
                drive_read_cycle(page_address(q, 1'b1));
                drive_bus_idle();
                repeat (no_reply_window) begin
                    @(negedge pcie_clk);
                    if (pcie_readdatavalid === 1'b1) begin
                        seen = 1'b1;
                    end
                end
                if (seen) begin
                    report_failure("pcie_readdatavalid for a read outside the register region");
                end
            end
            default: report_failure($sformatf("unknown operation %0h on test line %0d", op, t));
        endcase
        if (error_count != errors_before) begin
            tests_failed++;
            $display("test %0d op %0h queue %0d: failed", t, op, q);
        end else begin
            $display("test %0d op %0h queue %0d: ok", t, op, q);
        end
    endtask

    initial begin
        seed            = 32'h10c9;
        ref_c2f_tail    = '0;
        ref_c2f_kmem    = '0;
        pcie_address    = '0;
        pcie_read       = 1'b0;
        pcie_write      = 1'b0;
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        queue_rd_en     = 1'b0;
        tail_wr_en      = 1'b0;
        dma_queue       = '0;
        new_tail        = '0;
        $readmemh("verification/queue_regs_tests.txt", test_words);
        n_tests = 0;
        while (n_tests < max_tests && !$isunknown(test_words[n_tests*words_per_test])
               && test_words[n_tests*words_per_test] != op_end) begin
            n_tests++;
        end
        tests_loaded = 1'b1;
        if (n_tests == 0) begin
            report_failure("the test file holds no operations");
        end
        wait (pcie_reset_n === 1'b1);
        repeat (2) @(posedge pcie_clk);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, failed %0d, errors %0d", n_tests, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        wait (tests_loaded === 1'b1);
        repeat ((n_tests + 1) * cycles_per_test) @(posedge pcie_clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 (n_tests + 1) * cycles_per_test);
        $display("Verification failed");
        $finish;
    end

endmodule

/* verification/queue_regs_tests.txt */
// columns: op queue mask value expected, all hex
// op 1 bar write, 2 bar read (mask is the slot to check), 3 dma tail write, 4 dma read,
// op 5 write burst around a read (expected is slot 1), 6 read outside registers, 0 end
3 0 0 00000a00 0
3 1 0 00000a10 0
3 2 0 00000a20 0
3 3 0 00000a30 0
1 0 000e 10000000 0
1 1 000e 11000000 0
1 2 000e 12000000 0
1 3 000e 13000000 0
2 0 1 0 10000001
2 2 3 0 12000003
1 1 0402 21000000 0
2 1 2 0 11000002
2 1 1 0 21000001
1 3 000f 33000000 0
2 3 0 0 00000a30
3 2 0 0000beef 0
4 2 0 0 0000beef
2 2 0 0 0000beef
1 0 00d0 c0000000 0
2 3 4 0 c0000004
2 2 5 0 00000000
2 1 7 0 c0000007
1 2 2040 d0000000 0
2 0 6 0 d0000006
5 1 000e 50000000 50000201
4 1 0 0 00000a10
5 3 00de 60000000 60000201
2 0 4 0 60000204
6 0 0 0 0
6 3 0 0 0
3 1 0 00001234 0
4 1 0 0 00001234
0 0 0 0 0

/* all.f */
common/queue_table_pkg.sv
common/pcie_bar_pkg.sv
common/queue_table_if.sv
queue_table/queue_state_ram.sv
queue_table/queue_port_ctrl.sv
queue_table/dma_queue_port.sv
src/bar_reply.sv
src/pcie_queue_regs_top.sv
verification/tb_clock_gen.sv
verification/tb_pcie_queue_regs.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pcie_queue_regs
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Verification failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
